/* Makefile */
# Verilator flow for the coprocessor and its testbench

TB := tb_cop_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module cop_top \
		source/cop_pkg.sv source/cop_idecode.sv source/cop_cprs.sv \
		source/cop_palu.sv source/cop_rng.sv source/cop_ctrl.sv source/cop_top.sv
	verilator --lint-only --timing -f compile.f --top-module $(TB)

sim:
	verilator --binary --timing -f compile.f --top-module $(TB) -o sim_cop
	@out="$$(./obj_dir/sim_cop)"; echo "$$out"; \
		echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

/* compile.f */
source/cop_pkg.sv
source/cop_idecode.sv
source/cop_cprs.sv
source/cop_palu.sv
source/cop_rng.sv
source/cop_ctrl.sv
source/cop_top.sv
tests/tb_cop_top.sv

/* source/cop_cprs.sv */
`timescale 1ns/10ps
// Coprocessor register file
// Two combinational read ports, one byte-enabled write port,
// clear of every register on reset or init
module cop_cprs #(
    parameter int CPR_COUNT = 16                        // Number of CPRs
) (
    input  logic                        g_clk,
    input  logic                        g_resetn,
    input  logic                        i_init,         // Clear all
    input  logic [cop_pkg::CPR_AW-1:0]  i_crs1_addr,
    output logic [cop_pkg::XLEN-1:0]    o_crs1_rdata,
    input  logic [cop_pkg::CPR_AW-1:0]  i_crs2_addr,
    output logic [cop_pkg::XLEN-1:0]    o_crs2_rdata,
    input  logic [3:0]                  i_crd_ben,      // Byte write enables
    input  logic [cop_pkg::CPR_AW-1:0]  i_crd_addr,
    input  logic [cop_pkg::XLEN-1:0]    i_crd_wdata
);
    import cop_pkg::*;

    logic [XLEN-1:0] regs [CPR_COUNT];

    assign o_crs1_rdata = regs[i_crs1_addr];
    assign o_crs2_rdata = regs[i_crs2_addr];

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_init) begin
            for (int r = 0; r < CPR_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (i_crd_ben[b]) begin
                    regs[i_crd_addr][8*b +: 8] <= i_crd_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* source/cop_ctrl.sv */
`timescale 1ns/10ps
// CPU handshake control
// Idle/waiting/finished FSM, operand capture and response registers
module cop_ctrl (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  logic                      i_cpu_insn_req,
    output logic                      o_cop_insn_ack,
    input  logic [cop_pkg::XLEN-1:0]  i_cpu_insn_enc,
    input  logic [cop_pkg::XLEN-1:0]  i_cpu_rs1,
    input  logic [cop_pkg::XLEN-1:0]  i_cpu_rs2,
    input  logic                      i_cpu_insn_ack,   // Response taken
    input  logic                      i_n_wen,          // Next response values
    input  logic [4:0]                i_n_waddr,
    input  logic [cop_pkg::XLEN-1:0]  i_n_wdata,
    input  logic [2:0]                i_n_result,
    output logic                      o_insn_valid,
    output logic [cop_pkg::XLEN-1:0]  o_u_enc,          // To decoder and units
    output logic [cop_pkg::XLEN-1:0]  o_u_rs1,
    output logic [cop_pkg::XLEN-1:0]  o_u_rs2,
    output logic                      o_cop_wen,
    output logic [4:0]                o_cop_waddr,
    output logic [cop_pkg::XLEN-1:0]  o_cop_wdata,
    output logic [2:0]                o_cop_result,
    output logic                      o_cop_insn_rsp
);
    import cop_pkg::*;

    localparam logic [1:0] FSM_IDLE     = 2'd0;
    localparam logic [1:0] FSM_WAITING  = 2'd1;
    localparam logic [1:0] FSM_FINISHED = 2'd2;

    logic [1:0]      fsm;
    logic [1:0]      n_fsm;
    logic            n_ack;
    logic            n_rsp;
    logic            accept;
    logic            retire;
    logic [XLEN-1:0] r_enc;
    logic [XLEN-1:0] r_rs1;
    logic [XLEN-1:0] r_rs2;

    assign accept       = i_cpu_insn_req && o_cop_insn_ack;
    assign retire       = o_cop_insn_rsp && i_cpu_insn_ack;
    assign o_insn_valid = accept;       // Every unit finishes in one cycle

    // Live inputs in the accept cycle and held copies afterwards
    assign o_u_enc = accept ? i_cpu_insn_enc : r_enc;
    assign o_u_rs1 = accept ? i_cpu_rs1      : r_rs1;
    assign o_u_rs2 = accept ? i_cpu_rs2      : r_rs2;

    always_comb begin
        n_fsm = fsm;
        n_ack = 1'b0;
        n_rsp = 1'b0;
        case (fsm)
            FSM_WAITING: begin
                if (accept) begin
                    n_fsm = FSM_FINISHED;
                    n_rsp = 1'b1;
                end else begin
                    n_ack = 1'b1;
                end
            end
            FSM_FINISHED: begin
                if (retire) begin
                    n_fsm = FSM_WAITING;
                    n_ack = 1'b1;
                end else begin
                    n_rsp = 1'b1;           // Hold until the CPU takes it
                end
            end
            default: begin
                n_fsm = FSM_WAITING;        // Leave idle after reset
                n_ack = 1'b1;
            end
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            fsm            <= FSM_IDLE;
            o_cop_insn_ack <= 1'b0;
            o_cop_insn_rsp <= 1'b0;
            o_cop_wen      <= 1'b0;
            o_cop_waddr    <= '0;
            o_cop_wdata    <= '0;
            o_cop_result   <= '0;
        end else begin
            fsm            <= n_fsm;
            o_cop_insn_ack <= n_ack;
            o_cop_insn_rsp <= n_rsp;
            if (accept) begin
                o_cop_wen    <= i_n_wen;
                o_cop_waddr  <= i_n_waddr;
                o_cop_wdata  <= i_n_wdata;
                o_cop_result <= i_n_result;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            r_enc <= i_cpu_insn_enc;
            r_rs1 <= i_cpu_rs1;
            r_rs2 <= i_cpu_rs2;
        end
    end

endmodule

/* source/cop_idecode.sv */
`timescale 1ns/10ps
// Instruction decoder
// Splits the instruction word into fields through both union views
// and flags bad opcodes, classes, subclasses and pack widths
module cop_idecode (
    input  cop_pkg::cop_insn_u          i_enc,       // Instruction word
    output logic                        o_exception, // Illegal instruction
    output logic [3:0]                  o_class,
    output logic [2:0]                  o_sub,
    output logic [2:0]                  o_pw,
    output logic [cop_pkg::CPR_AW-1:0]  o_crs1,
    output logic [cop_pkg::CPR_AW-1:0]  o_crs2,
    output logic [cop_pkg::CPR_AW-1:0]  o_crd,
    output logic [4:0]                  o_rd,        // GPR destination
    output logic [cop_pkg::XLEN-1:0]    o_imm,
    output logic                        o_init       // Clear all CPRs
);
    import cop_pkg::*;

    logic bad_opcode;
    logic bad_class;
    logic bad_sub;
    logic bad_pw;

    assign o_class = i_enc.r.iclass;
    assign o_sub   = i_enc.r.sub;
    assign o_pw    = i_enc.r.pw;
    assign o_crs1  = i_enc.r.crs1[CPR_AW-1:0];
    assign o_crs2  = i_enc.r.crs2[CPR_AW-1:0];
    assign o_crd   = i_enc.r.crd[CPR_AW-1:0];
    assign o_rd    = i_enc.i.crd;
    assign o_imm   = {{(XLEN-13){1'b0}}, i_enc.i.imm}; // Immediate view

    assign bad_opcode = i_enc.r.opcode != COP_OPCODE;

    // Highest defined subclass per class
    always_comb begin
        bad_class = 1'b0;
        bad_sub   = 1'b0;
        case (o_class)
            ICLASS_PACKED_ARITH: bad_sub = o_sub > SCLASS_PSUB;
            ICLASS_BITWISE:      bad_sub = o_sub > SCLASS_XOR;
            ICLASS_MOVE:         bad_sub = o_sub > SCLASS_LDI;
            ICLASS_RANDOM:       bad_sub = o_sub > SCLASS_RSAMP;
            ICLASS_INIT:         bad_sub = o_sub != 3'd0;  // Single form
            default:             bad_class = 1'b1;
        endcase
    end

    assign bad_pw = (o_class == ICLASS_PACKED_ARITH) && (o_pw > PW_8); // Arith only

    assign o_exception = bad_opcode | bad_class | bad_sub | bad_pw;
    assign o_init      = (o_class == ICLASS_INIT) && !o_exception;

endmodule

/* source/cop_palu.sv */
`timescale 1ns/10ps
// Packed ALU
// Lane-wise add and subtract at 32, 16 or 8 bit pack width,
// bitwise and/or/xor, and the GPR/CPR move and load-immediate forms
module cop_palu (
    input  logic                      i_ivalid,     // Instruction for this unit
    input  logic [3:0]                i_class,
    input  logic [2:0]                i_sub,
    input  logic [2:0]                i_pw,
    input  logic [cop_pkg::XLEN-1:0]  i_imm,
    input  logic [cop_pkg::XLEN-1:0]  i_gpr_rs1,    // GPR operand
    input  logic [cop_pkg::XLEN-1:0]  i_rs1,        // CPR crs1
    input  logic [cop_pkg::XLEN-1:0]  i_rs2,        // CPR crs2
    output logic [3:0]                o_ben,
    output logic [cop_pkg::XLEN-1:0]  o_wdata,
    output logic [cop_pkg::XLEN-1:0]  o_gpr_wdata
);
    import cop_pkg::*;

    logic            sub_op;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] arith;
    logic [8:0]      byte_sum;
    logic            carry;
    logic            lane_start;
    logic [XLEN-1:0] result;
    logic            cpr_write;

    assign sub_op = i_sub == SCLASS_PSUB;
    assign op_b   = sub_op ? ~i_rs2 : i_rs2;  // a - b = a + ~b + 1

    // Byte-sliced adder with the carry chain cut at each lane boundary
    always_comb begin
        carry      = 1'b0;
        lane_start = 1'b0;
        byte_sum   = '0;
        arith      = '0;
        for (int j = 0; j < 4; j++) begin
            lane_start = (j == 0) || (i_pw == PW_8) || (i_pw == PW_16 && j == 2);
            byte_sum   = {1'b0, i_rs1[8*j +: 8]} + {1'b0, op_b[8*j +: 8]}
                       + {8'b0, lane_start ? sub_op : carry};
            arith[8*j +: 8] = byte_sum[7:0];
            carry      = byte_sum[8];
        end
    end

    always_comb begin
        result    = '0;
        cpr_write = 1'b1;
        case (i_class)
            ICLASS_PACKED_ARITH: result = arith;
            ICLASS_BITWISE: begin
                case (i_sub)
                    SCLASS_AND: result = i_rs1 & i_rs2;
                    SCLASS_OR:  result = i_rs1 | i_rs2;
                    default:    result = i_rs1 ^ i_rs2;
                endcase
            end
            ICLASS_MOVE: begin
                case (i_sub)
                    SCLASS_GPR2XCR: result = i_gpr_rs1;
                    SCLASS_LDI:     result = i_imm;
                    default:        cpr_write = 1'b0;   // XCR2GPR goes to GPR
                endcase
            end
            default: cpr_write = 1'b0;
        endcase
    end

    assign o_ben       = {4{i_ivalid && cpr_write}};
    assign o_wdata     = (i_ivalid && cpr_write) ? result : '0;
    assign o_gpr_wdata = (i_ivalid && i_class == ICLASS_MOVE && i_sub == SCLASS_XCR2GPR)
                       ? i_rs1 : '0;

endmodule

/* source/cop_pkg.sv */
// Shared definitions for the crypto coprocessor
// Data and CPR index widths, major opcode, class and subclass codes,
// pack width codes, result codes, LFSR feedback mask and the
// instruction word union with its register and immediate views
package cop_pkg;

    localparam int XLEN   = 32;                     // Data word width
    localparam int CPR_AW = 4;                      // CPR index width

    localparam logic [6:0] COP_OPCODE = 7'b0001011; // Custom-0 major opcode

    localparam logic [3:0] ICLASS_PACKED_ARITH = 4'd1;
    localparam logic [3:0] ICLASS_BITWISE      = 4'd2;
    localparam logic [3:0] ICLASS_MOVE         = 4'd3;
    localparam logic [3:0] ICLASS_RANDOM       = 4'd4;
    localparam logic [3:0] ICLASS_INIT         = 4'd5;

    localparam logic [2:0] SCLASS_PADD    = 3'd0;   // Packed arithmetic
    localparam logic [2:0] SCLASS_PSUB    = 3'd1;
    localparam logic [2:0] SCLASS_AND     = 3'd0;   // Bitwise
    localparam logic [2:0] SCLASS_OR      = 3'd1;
    localparam logic [2:0] SCLASS_XOR     = 3'd2;
    localparam logic [2:0] SCLASS_GPR2XCR = 3'd0;   // Moves
    localparam logic [2:0] SCLASS_XCR2GPR = 3'd1;
    localparam logic [2:0] SCLASS_LDI     = 3'd2;
    localparam logic [2:0] SCLASS_RSEED   = 3'd0;   // Random
    localparam logic [2:0] SCLASS_RSAMP   = 3'd1;

    localparam logic [2:0] PW_32 = 3'd0;
    localparam logic [2:0] PW_16 = 3'd1;
    localparam logic [2:0] PW_8  = 3'd2;

    localparam logic [2:0] INSN_SUCCESS = 3'd0;
    localparam logic [2:0] INSN_BAD_INS = 3'd1;

    localparam logic [31:0] RNG_TAPS = 32'h80200003; // Galois feedback mask

    typedef struct packed {
        logic [3:0] iclass;
        logic [2:0] sub;
        logic [4:0] crs2;                           // Low 4 bits index the CPRs
        logic [4:0] crs1;
        logic [2:0] pw;
        logic [4:0] crd;                            // Also GPR rd
        logic [6:0] opcode;
    } cop_insn_r_t;

    typedef struct packed {
        logic [3:0]  iclass;
        logic [2:0]  sub;
        logic [12:0] imm;                           // Zero-extended
        logic [4:0]  crd;
        logic [6:0]  opcode;
    } cop_insn_i_t;

    typedef union packed {
        cop_insn_r_t r;                             // Register form
        cop_insn_i_t i;                             // Immediate form
    } cop_insn_u;

endpackage

/* source/cop_rng.sv */
`timescale 1ns/10ps
// Random unit
// Galois LFSR, seeded from a CPR and sampled into a CPR
module cop_rng (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  logic                      i_ivalid,   // Instruction for this unit
    input  logic [2:0]                i_sub,
    input  logic [cop_pkg::XLEN-1:0]  i_rs1,      // Seed from crs1
    output logic [3:0]                o_ben,
    output logic [cop_pkg::XLEN-1:0]  o_wdata
);
    import cop_pkg::*;

    logic [XLEN-1:0] state;
    logic [XLEN-1:0] state_step;
    logic            seed;
    logic            sample;

    assign seed       = i_ivalid && i_sub == SCLASS_RSEED;
    assign sample     = i_ivalid && i_sub == SCLASS_RSAMP;
    assign state_step = (state >> 1) ^ (state[0] ? RNG_TAPS : '0);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state <= XLEN'(1);
        end else if (seed) begin
            state <= (i_rs1 == '0) ? XLEN'(1) : i_rs1;  // All-zero state locks up
        end else if (sample) begin
            state <= state_step;
        end
    end

    assign o_ben   = {4{sample}};         // Seed writes no CPR
    assign o_wdata = sample ? state : '0;

endmodule

/* source/cop_top.sv */
`timescale 1ns/10ps
// Coprocessor top level
// Handshake control, decoder, CPR file, packed ALU and random unit,
// class dispatch, CPR writeback merge and GPR response selection
module cop_top #(
    parameter int CPR_COUNT = 16
) (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  logic                      i_cpu_insn_req,
    output logic                      o_cop_insn_ack,
    input  logic [cop_pkg::XLEN-1:0]  i_cpu_insn_enc,
    input  logic [cop_pkg::XLEN-1:0]  i_cpu_rs1,
    input  logic [cop_pkg::XLEN-1:0]  i_cpu_rs2,
    output logic                      o_cop_wen,
    output logic [4:0]                o_cop_waddr,
    output logic [cop_pkg::XLEN-1:0]  o_cop_wdata,
    output logic [2:0]                o_cop_result,
    output logic                      o_cop_insn_rsp,
    input  logic                      i_cpu_insn_ack
);
    import cop_pkg::*;

    logic              insn_valid;
    logic [XLEN-1:0]   u_enc;
    logic [XLEN-1:0]   u_rs1;
    logic              id_exception;
    logic [3:0]        id_class;
    logic [2:0]        id_sub;
    logic [2:0]        id_pw;
    logic [CPR_AW-1:0] id_crs1;
    logic [CPR_AW-1:0] id_crs2;
    logic [CPR_AW-1:0] id_crd;
    logic [4:0]        id_rd;
    logic [XLEN-1:0]   id_imm;
    logic              id_init;
    logic [XLEN-1:0]   crs1_rdata;
    logic [XLEN-1:0]   crs2_rdata;
    logic              palu_ivalid;
    logic [3:0]        palu_ben;
    logic [XLEN-1:0]   palu_wdata;
    logic [XLEN-1:0]   palu_gpr_wdata;
    logic              rng_ivalid;
    logic [3:0]        rng_ben;
    logic [XLEN-1:0]   rng_wdata;
    logic              n_wen;
    logic [2:0]        n_result;

    // Illegal instructions reach no unit
    assign palu_ivalid = insn_valid && !id_exception && (id_class == ICLASS_PACKED_ARITH ||
                         id_class == ICLASS_BITWISE || id_class == ICLASS_MOVE);
    assign rng_ivalid  = insn_valid && !id_exception && id_class == ICLASS_RANDOM;

    assign n_wen    = !id_exception && id_class == ICLASS_MOVE && id_sub == SCLASS_XCR2GPR;
    assign n_result = id_exception ? INSN_BAD_INS : INSN_SUCCESS;

    cop_ctrl u_ctrl (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .i_cpu_insn_req (i_cpu_insn_req),
        .o_cop_insn_ack (o_cop_insn_ack),
        .i_cpu_insn_enc (i_cpu_insn_enc),
        .i_cpu_rs1      (i_cpu_rs1),
        .i_cpu_rs2      (i_cpu_rs2),
        .i_cpu_insn_ack (i_cpu_insn_ack),
        .i_n_wen        (n_wen),
        .i_n_waddr      (id_rd),
        .i_n_wdata      (palu_gpr_wdata),       // Only moves return to a GPR
        .i_n_result     (n_result),
        .o_insn_valid   (insn_valid),
        .o_u_enc        (u_enc),
        .o_u_rs1        (u_rs1),
        .o_u_rs2        (),                     // No current instruction reads GPR rs2
        .o_cop_wen      (o_cop_wen),
        .o_cop_waddr    (o_cop_waddr),
        .o_cop_wdata    (o_cop_wdata),
        .o_cop_result   (o_cop_result),
        .o_cop_insn_rsp (o_cop_insn_rsp)
    );

    cop_idecode u_idecode (
        .i_enc       (u_enc),
        .o_exception (id_exception),
        .o_class     (id_class),
        .o_sub       (id_sub),
        .o_pw        (id_pw),
        .o_crs1      (id_crs1),
        .o_crs2      (id_crs2),
        .o_crd       (id_crd),
        .o_rd        (id_rd),
        .o_imm       (id_imm),
        .o_init      (id_init)
    );

    cop_cprs #(
        .CPR_COUNT (CPR_COUNT)
    ) u_cprs (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .i_init       (id_init && insn_valid),  // Clear once, at accept
        .i_crs1_addr  (id_crs1),
        .o_crs1_rdata (crs1_rdata),
        .i_crs2_addr  (id_crs2),
        .o_crs2_rdata (crs2_rdata),
        .i_crd_ben    (palu_ben | rng_ben),     // Idle units drive zero
        .i_crd_addr   (id_crd),
        .i_crd_wdata  (palu_wdata | rng_wdata)
    );

    cop_palu u_palu (
        .i_ivalid    (palu_ivalid),
        .i_class     (id_class),
        .i_sub       (id_sub),
        .i_pw        (id_pw),
        .i_imm       (id_imm),
        .i_gpr_rs1   (u_rs1),
        .i_rs1       (crs1_rdata),
        .i_rs2       (crs2_rdata),
        .o_ben       (palu_ben),
        .o_wdata     (palu_wdata),
        .o_gpr_wdata (palu_gpr_wdata)
    );

    cop_rng u_rng (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_ivalid (rng_ivalid),
        .i_sub    (id_sub),
        .i_rs1    (crs1_rdata),
        .o_ben    (rng_ben),
        .o_wdata  (rng_wdata)
    );

endmodule

/* tests/cop_cases.txt */
// enc      gpr_rs1  gpr_rs2  wen waddr wdata    result   (all hex)
// c3 = 80ff7ff0, c4 = 810281f5; arithmetic results land in c5
3000008B 12345678 00000000 0 01 00000000 0
3200828B 00000000 00000000 1 05 12345678 0
35ABC30B 00000000 00000000 0 06 00000000 0
3203038B 00000000 00000000 1 07 00001abc 0
3000018B 80ff7ff0 00000000 0 03 00000000 0
3000020B 810281f5 00000000 0 04 00000000 0
1041828B 00000000 00000000 0 05 00000000 0
3202850B 00000000 00000000 1 0a 020201e5 0
1041928B 00000000 00000000 0 05 00000000 0
3202850B 00000000 00000000 1 0a 020101e5 0
1041A28B 00000000 00000000 0 05 00000000 0
3202850B 00000000 00000000 1 0a 010100e5 0
1241828B 00000000 00000000 0 05 00000000 0
3202850B 00000000 00000000 1 0a fffcfdfb 0
1241928B 00000000 00000000 0 05 00000000 0
3202850B 00000000 00000000 1 0a fffdfdfb 0
1241A28B 00000000 00000000 0 05 00000000 0
3202850B 00000000 00000000 1 0a fffdfefb 0
2041828B 00000000 00000000 0 05 00000000 0
3202850B 00000000 00000000 1 0a 800201f0 0
2241828B 00000000 00000000 0 05 00000000 0
3202850B 00000000 00000000 1 0a 81fffff5 0
2441828B 00000000 00000000 0 05 00000000 0
3202850B 00000000 00000000 1 0a 01fdfe05 0
3000038B 12345679 00000000 0 07 00000000 0
4003800B 00000000 00000000 0 00 00000000 0
4200040B 00000000 00000000 0 08 00000000 0
3204058B 00000000 00000000 1 0b 12345679 0
4200048B 00000000 00000000 0 09 00000000 0
3204860B 00000000 00000000 1 0c 893a2b3f 0
5000000B 00000000 00000000 0 00 00000000 0
3200828B 00000000 00000000 1 05 00000000 0
300000B3 deadbeef 00000000 0 01 00000000 1
7000008B deadbeef 00000000 0 01 00000000 1
1041B28B 00000000 00000000 0 05 00000000 1
3200828B 00000000 00000000 1 05 00000000 0
3202850B 00000000 00000000 1 0a 00000000 0

/* tests/tb_cop_top.sv */
`timescale 1ns/10ps
// Testbench for the coprocessor top level
// Reads instruction cases from a text file, drives the request and
// response handshakes and checks GPR write enable, address, data
// and result code of every response
module tb_cop_top;

    localparam int TIMEOUT = 20;                    // Cycles allowed per wait

    logic        g_clk;
    logic        g_resetn;
    logic        i_cpu_insn_req;
    logic [31:0] i_cpu_insn_enc;
    logic [31:0] i_cpu_rs1;
    logic [31:0] i_cpu_rs2;
    logic        i_cpu_insn_ack;
    logic        o_cop_insn_ack;
    logic        o_cop_wen;
    logic [4:0]  o_cop_waddr;
    logic [31:0] o_cop_wdata;
    logic [2:0]  o_cop_result;
    logic        o_cop_insn_rsp;

    int          errors;                            // Wrong values
    int          aborts;                            // Timeouts, missing file
    int          case_num;
    int          fd;
    int          n_fields;
    bit          done_rd;
    bit          case_ok;
    string       line;
    logic [31:0] c_enc;                             // Current case columns
    logic [31:0] c_rs1;
    logic [31:0] c_rs2;
    logic [31:0] c_wen;
    logic [31:0] c_waddr;
    logic [31:0] c_wdata;
    logic [31:0] c_res;

    cop_top #(
        .CPR_COUNT (16)
    ) u_dut (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .i_cpu_insn_req (i_cpu_insn_req),
        .o_cop_insn_ack (o_cop_insn_ack),
        .i_cpu_insn_enc (i_cpu_insn_enc),
        .i_cpu_rs1      (i_cpu_rs1),
        .i_cpu_rs2      (i_cpu_rs2),
        .o_cop_wen      (o_cop_wen),
        .o_cop_waddr    (o_cop_waddr),
        .o_cop_wdata    (o_cop_wdata),
        .o_cop_result   (o_cop_result),
        .o_cop_insn_rsp (o_cop_insn_rsp),
        .i_cpu_insn_ack (i_cpu_insn_ack)
    );

    always #4 g_clk = ~g_clk;                       // 8 ns period

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("ERR %0t: case %0d %s is %0h, expected %0h", $time, case_num, what, got, exp);
    endtask

    // Response outputs against the case columns
    task automatic compare_response();
        if (o_cop_insn_rsp !== 1'b1) report_mismatch("rsp", 32'(o_cop_insn_rsp), 32'd1);
        if (o_cop_insn_ack !== 1'b0) report_mismatch("ack", 32'(o_cop_insn_ack), 32'd0);
        if (o_cop_wen !== c_wen[0]) report_mismatch("wen", 32'(o_cop_wen), c_wen);
        if (o_cop_waddr !== c_waddr[4:0]) report_mismatch("waddr", 32'(o_cop_waddr), c_waddr);
        if (o_cop_wdata !== c_wdata) report_mismatch("wdata", o_cop_wdata, c_wdata);
        if (o_cop_result !== c_res[2:0]) report_mismatch("result", 32'(o_cop_result), c_res);
    endtask

    task automatic wait_for_ack(output bit ok);
        int n;
        n = 0;
        while (o_cop_insn_ack !== 1'b1 && n < TIMEOUT) begin
            @(negedge g_clk);
            n++;
        end
        ok = (o_cop_insn_ack === 1'b1);
        if (!ok) $display("Timeout: no acknowledge for case %0d", case_num);
    endtask

    task automatic wait_for_rsp(output bit ok, output int cycles);
        cycles = 0;
        while (o_cop_insn_rsp !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge g_clk);
            cycles++;
        end
        ok = (o_cop_insn_rsp === 1'b1);
        if (!ok) $display("Timeout: no response for case %0d", case_num);
    endtask

    // One instruction through request, response and retire
    task automatic run_case(output bit ok);
        bit got;
        int lat;
        int delay;
        ok = 0;
        repeat ($urandom % 4) @(negedge g_clk);     // Idle gap
        i_cpu_insn_req = 1'b1;
        i_cpu_insn_enc = c_enc;
        i_cpu_rs1      = c_rs1;
        i_cpu_rs2      = c_rs2;
        wait_for_ack(got);
        if (!got) return;
        @(negedge g_clk);                           // Accepted at this rising edge
        i_cpu_insn_req = 1'b0;
        i_cpu_insn_enc = '0;
        i_cpu_rs1      = '0;
        i_cpu_rs2      = '0;
        wait_for_rsp(got, lat);
        if (!got) return;
        if (lat != 0) report_mismatch("response latency", 32'(lat + 1), 32'd1);
        compare_response();
        delay = $urandom % 4;                       // CPU back-pressure
        if (c_res != 0 && delay < 2) delay = 2;     // Hold test on bad instructions
        repeat (delay) begin
            @(negedge g_clk);
            compare_response();                     // Must not move while held
        end
        i_cpu_insn_ack = 1'b1;
        @(negedge g_clk);                           // Retire edge
        i_cpu_insn_ack = 1'b0;
        if (o_cop_insn_rsp !== 1'b0) report_mismatch("rsp after retire", 32'(o_cop_insn_rsp), 0);
        if (o_cop_insn_ack !== 1'b1) report_mismatch("ack after retire", 32'(o_cop_insn_ack), 1);
        ok = 1;
    endtask

    initial begin
        g_clk          = 1'b0;
        g_resetn       = 1'b0;
        i_cpu_insn_req = 1'b0;
        i_cpu_insn_enc = '0;
        i_cpu_rs1      = '0;
        i_cpu_rs2      = '0;
        i_cpu_insn_ack = 1'b0;
        errors         = 0;
        aborts         = 0;
        case_num       = 0;
        void'($urandom(32'h708c5ef9));              // Fixed seed
        repeat (10) @(negedge g_clk);               // 10 cycles in reset
        if (o_cop_insn_ack !== 1'b0) report_mismatch("ack in reset", 32'(o_cop_insn_ack), 0);
        if (o_cop_insn_rsp !== 1'b0) report_mismatch("rsp in reset", 32'(o_cop_insn_rsp), 0);
        if (o_cop_wen !== 1'b0) report_mismatch("wen in reset", 32'(o_cop_wen), 0);
        if (o_cop_waddr !== '0) report_mismatch("waddr in reset", 32'(o_cop_waddr), 0);
        if (o_cop_wdata !== '0) report_mismatch("wdata in reset", o_cop_wdata, 0);
        if (o_cop_result !== '0) report_mismatch("result in reset", 32'(o_cop_result), 0);
        g_resetn = 1'b1;
        @(negedge g_clk);                           // One edge after release
        if (o_cop_insn_ack !== 1'b1) report_mismatch("ack after reset", 32'(o_cop_insn_ack), 1);
        fd = $fopen("tests/cop_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file tests/cop_cases.txt");
            aborts++;
        end else begin
            done_rd = 0;
            while (!done_rd) begin
                if ($fgets(line, fd) == 0) begin
                    done_rd = 1;
                end else begin
                    n_fields = $sscanf(line, "%h %h %h %h %h %h %h", c_enc, c_rs1, c_rs2,
                                       c_wen, c_waddr, c_wdata, c_res);
                    if (n_fields == 7) begin        // Comment lines give no fields
                        case_num++;
                        run_case(case_ok);
                        if (!case_ok) begin
                            aborts++;
                            done_rd = 1;
                        end
                    end
                end
            end
            $fclose(fd);
        end
        $display("Cases: %0d, errors: %0d, aborted: %0d", case_num, errors, aborts);
        if (errors == 0 && aborts == 0 && case_num > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
